//--- include/pr_shell_defs.svh
`ifndef PR_SHELL_DEFS_SVH
`define PR_SHELL_DEFS_SVH

// Line memory geometry
`define PR_DATA_W   128
`define PR_STRB_W   16
`define PR_LINE_AW  8

// DMA byte address, only bits 11:4 select a line
`define PR_ADDR_W   26

// Descriptor and digest width
`define PR_DESC_W   64

// Rotating status channel
`define PR_STAT_AW  3
`define PR_STAT_N   3

`endif

//--- hw/pr_shell_pkg.sv
`include "pr_shell_defs.svh"

package pr_shell_pkg;

  typedef logic [`PR_DATA_W-1:0]  line_t;
  typedef logic [`PR_STRB_W-1:0]  strb_t;
  typedef logic [`PR_ADDR_W-1:0]  dma_addr_t;
  typedef logic [`PR_LINE_AW-1:0] line_idx_t;
  typedef logic [`PR_DESC_W-1:0]  digest_t;
  typedef logic [31:0]            stat_t;
  typedef logic [`PR_STAT_AW-1:0] stat_addr_t;

  // Line count of zero means a full 256 line pass
  typedef struct packed {
    logic [15:0] tag;
    logic [23:0] rsvd;
    line_idx_t   first_line;
    logic [7:0]  line_cnt;
    logic [7:0]  done;
  } desc_t;

  typedef struct packed {
    line_t     data;
    dma_addr_t addr;
    strb_t     strb;
    logic      last;
  } dma_wr_s;

  typedef struct packed {
    dma_addr_t addr;
  } dma_rd_s;

  typedef struct packed {
    logic                  is_2nd;
    logic [`PR_DESC_W-1:0] payload;
  } out_desc_s;

  typedef enum logic [2:0] {
    st_idle,
    st_read,
    st_fold,
    st_emit_first,
    st_emit_second
  } eng_state_e;

endpackage

//--- hw/pipe_reg_slice.sv
`timescale 1ns/10ps

module pipe_reg_slice #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] s_data,
  input  logic             s_valid,
  output logic             s_ready,
  output logic [WIDTH-1:0] m_data,
  output logic             m_valid,
  input  logic             m_ready
);

  logic [WIDTH-1:0] skid_data_q;
  logic             skid_valid_q;
  logic             m_free;
  logic             s_xfer;

  // Ready comes straight from a flop, so it only drops once the skid entry is in use
  assign s_ready = !skid_valid_q;
  assign m_free  = !m_valid || m_ready;
  assign s_xfer  = s_valid && s_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_valid      <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (m_free) begin
      // Skid entry drains first to keep order
      if (skid_valid_q) begin
        m_valid      <= 1'b1;
        skid_valid_q <= 1'b0;
      end else begin
        m_valid <= s_valid;
      end
    end else if (s_xfer) begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (m_free) begin
      if (skid_valid_q) begin
        m_data <= skid_data_q;
      end else if (s_valid) begin
        m_data <= s_data;
      end
    end else if (s_xfer) begin
      skid_data_q <= s_data;
    end
  end

  // Output beat held until taken
  a_hold_stall: assert property (
    @(posedge clk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_data)
  );

endmodule

//--- hw/line_mem.sv
`timescale 1ns/10ps
`include "pr_shell_defs.svh"

module line_mem (
  input  logic                    clk,
  input  pr_shell_pkg::dma_wr_s   wr,
  input  logic                    wr_valid,
  input  pr_shell_pkg::line_idx_t rd_idx,
  output pr_shell_pkg::line_t     rd_data,
  input  pr_shell_pkg::line_idx_t eng_idx,
  output pr_shell_pkg::line_t     eng_data
);

  localparam int num_lines = 1 << `PR_LINE_AW;
  localparam int byte_sh   = $clog2(`PR_STRB_W);

  pr_shell_pkg::line_t     mem [num_lines];
  pr_shell_pkg::line_idx_t wr_idx;

  // Upper address bits alias onto the 4 KiB window
  assign wr_idx = wr.addr[byte_sh +: `PR_LINE_AW];

  //////////////////////////////////////////////////////////////////////
  // Byte-strobed write port
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      for (int b = 0; b < `PR_STRB_W; b++) begin
        if (wr.strb[b]) begin
          mem[wr_idx][8*b +: 8] <= wr.data[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read ports, one cycle latency each
  //////////////////////////////////////////////////////////////////////

  // DMA side
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_idx];
  end

  // Engine side, old data on a same-cycle write
  always_ff @(posedge clk) begin
    eng_data <= mem[eng_idx];
  end

endmodule

//--- hw/desc_engine_fsm.sv
`timescale 1ns/10ps
`include "pr_shell_defs.svh"

module desc_engine_fsm (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    core_reset,
  input  pr_shell_pkg::desc_t     desc,
  input  logic                    desc_valid,
  output logic                    desc_taken,
  output pr_shell_pkg::line_idx_t eng_idx,
  input  pr_shell_pkg::line_t     eng_data,
  output pr_shell_pkg::out_desc_s out_beat,
  output logic                    out_valid,
  input  logic                    out_ready,
  output logic                    desc_done,
  output logic                    line_folded
);

  pr_shell_pkg::eng_state_e state_q;
  pr_shell_pkg::eng_state_e state_d;
  pr_shell_pkg::desc_t      desc_q;
  pr_shell_pkg::desc_t      echo_desc;
  pr_shell_pkg::digest_t    digest_q;
  pr_shell_pkg::line_idx_t  idx_q;
  logic [`PR_LINE_AW:0]     left_q;
  logic                     take;

  assign desc_taken  = (state_q == pr_shell_pkg::st_idle);
  assign take        = desc_valid && desc_taken;
  assign eng_idx     = idx_q;
  assign line_folded = (state_q == pr_shell_pkg::st_fold);
  assign out_valid   = (state_q == pr_shell_pkg::st_emit_first) ||
                       (state_q == pr_shell_pkg::st_emit_second);
  assign desc_done   = (state_q == pr_shell_pkg::st_emit_second) && out_ready;

  always_comb begin
    echo_desc      = desc_q;
    echo_desc.done = 8'h01;
    out_beat.is_2nd  = (state_q == pr_shell_pkg::st_emit_second);
    out_beat.payload = out_beat.is_2nd ? digest_q : echo_desc;
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      pr_shell_pkg::st_idle:        if (desc_valid) state_d = pr_shell_pkg::st_read;
      pr_shell_pkg::st_read:        state_d = pr_shell_pkg::st_fold;
      pr_shell_pkg::st_fold:        if (left_q == 1) state_d = pr_shell_pkg::st_emit_first;
      pr_shell_pkg::st_emit_first:  if (out_ready) state_d = pr_shell_pkg::st_emit_second;
      pr_shell_pkg::st_emit_second: if (out_ready) state_d = pr_shell_pkg::st_idle;
      default:                      state_d = pr_shell_pkg::st_idle;
    endcase
    if (core_reset) state_d = pr_shell_pkg::st_idle;
  end

  // Memory reads idx_q every cycle, so fold sees one line per cycle after st_read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= pr_shell_pkg::st_idle;
      idx_q   <= '0;
      left_q  <= '0;
    end else begin
      state_q <= state_d;
      if (take) begin
        idx_q  <= desc.first_line;
        // A zero count becomes 256
        left_q <= {desc.line_cnt == '0, desc.line_cnt};
      end else if (state_q == pr_shell_pkg::st_read) begin
        idx_q <= idx_q + 1'b1;
      end else if (line_folded) begin
        idx_q  <= idx_q + 1'b1;
        left_q <= left_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      desc_q   <= desc;
      digest_q <= '0;
    end else if (line_folded) begin
      digest_q <= digest_q ^ eng_data[`PR_DATA_W-1:`PR_DESC_W] ^ eng_data[`PR_DESC_W-1:0];
    end
  end

  // Lines still to fold never run out mid pass
  a_fold_left: assert property (
    @(posedge clk) disable iff (!rst_n) line_folded |-> left_q != '0);

  // Output beat held until taken
  a_beat_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready && !core_reset |=> out_valid && $stable(out_beat));

endmodule

//--- hw/event_counters.sv
`timescale 1ns/10ps
`include "pr_shell_defs.svh"

module event_counters (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     desc_done,
  input  logic                     line_folded,
  input  logic                     burst_end,
  output pr_shell_pkg::stat_t      status_data,
  output pr_shell_pkg::stat_addr_t status_addr
);

  pr_shell_pkg::stat_t      desc_cnt_q;
  pr_shell_pkg::stat_t      line_cnt_q;
  pr_shell_pkg::stat_t      burst_cnt_q;
  pr_shell_pkg::stat_addr_t addr_q;

  // Counters wrap at 2^32
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      desc_cnt_q  <= '0;
      line_cnt_q  <= '0;
      burst_cnt_q <= '0;
    end else begin
      if (desc_done) desc_cnt_q <= desc_cnt_q + 1'b1;
      if (line_folded) line_cnt_q <= line_cnt_q + 1'b1;
      if (burst_end) burst_cnt_q <= burst_cnt_q + 1'b1;
    end
  end

  // Address steps 0, 1, 2, 0 every cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (addr_q == pr_shell_pkg::stat_addr_t'(`PR_STAT_N - 1)) begin
      addr_q <= '0;
    end else begin
      addr_q <= addr_q + 1'b1;
    end
  end

  assign status_addr = addr_q;

  always_comb begin
    unique case (addr_q)
      pr_shell_pkg::stat_addr_t'(0): status_data = desc_cnt_q;
      pr_shell_pkg::stat_addr_t'(1): status_data = line_cnt_q;
      pr_shell_pkg::stat_addr_t'(2): status_data = burst_cnt_q;
      default:                       status_data = '0;
    endcase
  end

endmodule

//--- hw/packet_core.sv
`timescale 1ns/10ps
`include "pr_shell_defs.svh"

module packet_core (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     core_reset,
  input  pr_shell_pkg::dma_wr_s    dma_wr,
  input  logic                     dma_wr_valid,
  output logic                     dma_wr_ready,
  input  pr_shell_pkg::dma_rd_s    dma_rd,
  input  logic                     dma_rd_valid,
  output logic                     dma_rd_ready,
  output pr_shell_pkg::line_t      rd_resp_data,
  output logic                     rd_resp_valid,
  input  logic                     rd_resp_ready,
  input  pr_shell_pkg::desc_t      in_desc,
  input  logic                     in_desc_valid,
  output logic                     in_desc_taken,
  output pr_shell_pkg::out_desc_s  out_desc,
  output logic                     out_desc_valid,
  input  logic                     out_desc_ready,
  output pr_shell_pkg::stat_t      status_data,
  output pr_shell_pkg::stat_addr_t status_addr
);

  localparam int byte_sh = $clog2(`PR_STRB_W);

  pr_shell_pkg::line_idx_t rd_idx;
  pr_shell_pkg::line_idx_t rd_idx_q;
  pr_shell_pkg::line_idx_t eng_idx;
  pr_shell_pkg::line_t     mem_rd_data;
  pr_shell_pkg::line_t     eng_data;
  logic                    rd_take;
  logic                    rd_pend_q;
  logic                    pend_move;
  logic                    desc_done;
  logic                    line_folded;
  logic                    burst_end;

  //////////////////////////////////////////////////////////////////////
  // DMA read response path
  //////////////////////////////////////////////////////////////////////

  // Pending read moves on when the response register is empty or draining
  assign pend_move    = rd_pend_q && (!rd_resp_valid || rd_resp_ready);
  assign dma_rd_ready = !rd_pend_q || pend_move;
  assign rd_take      = dma_rd_valid && dma_rd_ready;
  // Held index re-reads the pending line while the response stage is blocked
  assign rd_idx       = rd_take ? dma_rd.addr[byte_sh +: `PR_LINE_AW] : rd_idx_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend_q     <= 1'b0;
      rd_resp_valid <= 1'b0;
    end else begin
      if (rd_take) rd_pend_q <= 1'b1;
      else if (pend_move) rd_pend_q <= 1'b0;
      if (pend_move) rd_resp_valid <= 1'b1;
      else if (rd_resp_ready) rd_resp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    rd_idx_q <= rd_idx;
    if (pend_move) rd_resp_data <= mem_rd_data;
  end

  //////////////////////////////////////////////////////////////////////
  // Memory, engine and counters
  //////////////////////////////////////////////////////////////////////
  assign dma_wr_ready = 1'b1;
  assign burst_end    = dma_wr_valid && dma_wr.last;

  line_mem line_mem_i (
    .clk      (clk),
    .wr       (dma_wr),
    .wr_valid (dma_wr_valid),
    .rd_idx   (rd_idx),
    .rd_data  (mem_rd_data),
    .eng_idx  (eng_idx),
    .eng_data (eng_data)
  );

  desc_engine_fsm desc_engine_fsm_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .core_reset  (core_reset),
    .desc        (in_desc),
    .desc_valid  (in_desc_valid),
    .desc_taken  (in_desc_taken),
    .eng_idx     (eng_idx),
    .eng_data    (eng_data),
    .out_beat    (out_desc),
    .out_valid   (out_desc_valid),
    .out_ready   (out_desc_ready),
    .desc_done   (desc_done),
    .line_folded (line_folded)
  );

  event_counters event_counters_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .desc_done   (desc_done),
    .line_folded (line_folded),
    .burst_end   (burst_end),
    .status_data (status_data),
    .status_addr (status_addr)
  );

endmodule

//--- hw/pr_core_shell.sv
`timescale 1ns/10ps

module pr_core_shell (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     core_reset,
  input  pr_shell_pkg::dma_wr_s    dma_wr,
  input  logic                     dma_wr_valid,
  output logic                     dma_wr_ready,
  input  pr_shell_pkg::dma_rd_s    dma_rd,
  input  logic                     dma_rd_valid,
  output logic                     dma_rd_ready,
  output pr_shell_pkg::line_t      dma_rd_resp_data,
  output logic                     dma_rd_resp_valid,
  input  logic                     dma_rd_resp_ready,
  input  pr_shell_pkg::desc_t      in_desc,
  input  logic                     in_desc_valid,
  output logic                     in_desc_taken,
  output pr_shell_pkg::out_desc_s  out_desc,
  output logic                     out_desc_valid,
  input  logic                     out_desc_ready,
  output pr_shell_pkg::stat_t      core_status_data,
  output pr_shell_pkg::stat_addr_t core_status_addr
);

  logic [1:0]               rst_sync_q;
  logic                     rst_sync_n;
  logic                     core_reset_q;
  logic                     desc_rst_n;
  pr_shell_pkg::dma_wr_s    wr_r;
  logic                     wr_valid_r;
  logic                     wr_ready_r;
  pr_shell_pkg::dma_rd_s    rd_r;
  logic                     rd_valid_r;
  logic                     rd_ready_r;
  pr_shell_pkg::line_t      resp_n;
  logic                     resp_valid_n;
  logic                     resp_ready_n;
  pr_shell_pkg::desc_t      desc_r;
  logic                     desc_valid_r;
  logic                     desc_taken_r;
  pr_shell_pkg::out_desc_s  out_n;
  logic                     out_valid_n;
  logic                     out_ready_n;
  pr_shell_pkg::stat_t      status_data_n;
  pr_shell_pkg::stat_addr_t status_addr_n;

  //////////////////////////////////////////////////////////////////////
  // Reset synchronizer and core reset level
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) rst_sync_q <= '0;
    else rst_sync_q <= {rst_sync_q[0], 1'b1};
  end

  assign rst_sync_n = rst_sync_q[1];

  always_ff @(posedge clk or negedge rst_sync_n) begin
    if (!rst_sync_n) core_reset_q <= 1'b0;
    else core_reset_q <= core_reset;
  end

  // Descriptor channels also clear on core reset
  assign desc_rst_n = rst_sync_n && !core_reset_q;

  //////////////////////////////////////////////////////////////////////
  // Boundary slices
  //////////////////////////////////////////////////////////////////////
  pipe_reg_slice #(.WIDTH($bits(pr_shell_pkg::dma_wr_s))) dma_wr_slice (
    .clk (clk), .rst_n (rst_sync_n),
    .s_data (dma_wr), .s_valid (dma_wr_valid), .s_ready (dma_wr_ready),
    .m_data (wr_r), .m_valid (wr_valid_r), .m_ready (wr_ready_r)
  );

  pipe_reg_slice #(.WIDTH($bits(pr_shell_pkg::dma_rd_s))) dma_rd_slice (
    .clk (clk), .rst_n (rst_sync_n),
    .s_data (dma_rd), .s_valid (dma_rd_valid), .s_ready (dma_rd_ready),
    .m_data (rd_r), .m_valid (rd_valid_r), .m_ready (rd_ready_r)
  );

  pipe_reg_slice #(.WIDTH($bits(pr_shell_pkg::line_t))) dma_resp_slice (
    .clk (clk), .rst_n (rst_sync_n),
    .s_data (resp_n), .s_valid (resp_valid_n), .s_ready (resp_ready_n),
    .m_data (dma_rd_resp_data), .m_valid (dma_rd_resp_valid), .m_ready (dma_rd_resp_ready)
  );

  pipe_reg_slice #(.WIDTH($bits(pr_shell_pkg::desc_t))) in_desc_slice (
    .clk (clk), .rst_n (desc_rst_n),
    .s_data (in_desc), .s_valid (in_desc_valid), .s_ready (in_desc_taken),
    .m_data (desc_r), .m_valid (desc_valid_r), .m_ready (desc_taken_r)
  );

  pipe_reg_slice #(.WIDTH($bits(pr_shell_pkg::out_desc_s))) out_desc_slice (
    .clk (clk), .rst_n (desc_rst_n),
    .s_data (out_n), .s_valid (out_valid_n), .s_ready (out_ready_n),
    .m_data (out_desc), .m_valid (out_desc_valid), .m_ready (out_desc_ready)
  );

  always_ff @(posedge clk or negedge rst_sync_n) begin
    if (!rst_sync_n) begin
      core_status_data <= '0;
      core_status_addr <= '0;
    end else begin
      core_status_data <= status_data_n;
      core_status_addr <= status_addr_n;
    end
  end

  packet_core packet_core_i (
    .clk            (clk),
    .rst_n          (rst_sync_n),
    .core_reset     (core_reset_q),
    .dma_wr         (wr_r),
    .dma_wr_valid   (wr_valid_r),
    .dma_wr_ready   (wr_ready_r),
    .dma_rd         (rd_r),
    .dma_rd_valid   (rd_valid_r),
    .dma_rd_ready   (rd_ready_r),
    .rd_resp_data   (resp_n),
    .rd_resp_valid  (resp_valid_n),
    .rd_resp_ready  (resp_ready_n),
    .in_desc        (desc_r),
    .in_desc_valid  (desc_valid_r),
    .in_desc_taken  (desc_taken_r),
    .out_desc       (out_n),
    .out_desc_valid (out_valid_n),
    .out_desc_ready (out_ready_n),
    .status_data    (status_data_n),
    .status_addr    (status_addr_n)
  );

endmodule

//--- verif/pr_core_shell_tb.sv
`timescale 1ns/10ps
`include "pr_shell_defs.svh"

module pr_core_shell_tb;

  localparam int tmo      = 1000;
  localparam int desc_tmo = 5000;
  localparam int n_steps  = 16;

  typedef enum logic [1:0] {op_wr, op_rd, op_desc, op_core_reset} op_e;

  typedef struct packed {
    op_e                     op;
    pr_shell_pkg::line_idx_t line;
    logic [8:0]              cnt;
    logic                    part;
    logic                    stall;
  } step_t;

  // Operation, first line, line count, partial strobes, random ready stalls
  step_t stim [n_steps] = '{
    '{op_wr,         8'd0,   9'd256, 1'b0, 1'b0},
    '{op_rd,         8'd0,   9'd16,  1'b0, 1'b0},
    '{op_wr,         8'd8,   9'd8,   1'b1, 1'b0},
    '{op_rd,         8'd4,   9'd16,  1'b0, 1'b1},
    '{op_desc,       8'd2,   9'd5,   1'b0, 1'b0},
    '{op_desc,       8'd250, 9'd10,  1'b0, 1'b1},
    '{op_desc,       8'd64,  9'd0,   1'b0, 1'b1},
    '{op_core_reset, 8'd0,   9'd0,   1'b0, 1'b0},
    '{op_wr,         8'd3,   9'd4,   1'b1, 1'b0},
    '{op_desc,       8'd0,   9'd12,  1'b0, 1'b1},
    '{op_rd,         8'd240, 9'd32,  1'b0, 1'b1},
    '{op_desc,       8'd100, 9'd1,   1'b0, 1'b0},
    '{op_core_reset, 8'd0,   9'd0,   1'b0, 1'b0},
    '{op_desc,       8'd200, 9'd20,  1'b0, 1'b1},
    '{op_wr,         8'd250, 9'd12,  1'b1, 1'b0},
    '{op_rd,         8'd248, 9'd16,  1'b0, 1'b1}
  };

  logic                     clk;
  logic                     rst_n;
  logic                     core_reset;
  pr_shell_pkg::dma_wr_s    dma_wr;
  logic                     dma_wr_valid;
  logic                     dma_wr_ready;
  pr_shell_pkg::dma_rd_s    dma_rd;
  logic                     dma_rd_valid;
  logic                     dma_rd_ready;
  pr_shell_pkg::line_t      dma_rd_resp_data;
  logic                     dma_rd_resp_valid;
  logic                     dma_rd_resp_ready = 1'b1;
  pr_shell_pkg::desc_t      in_desc;
  logic                     in_desc_valid;
  logic                     in_desc_taken;
  pr_shell_pkg::out_desc_s  out_desc;
  logic                     out_desc_valid;
  logic                     out_desc_ready = 1'b1;
  pr_shell_pkg::stat_t      core_status_data;
  pr_shell_pkg::stat_addr_t core_status_addr;

  pr_shell_pkg::line_t     mem_model [256];
  pr_shell_pkg::line_t     resp_q [$];
  pr_shell_pkg::out_desc_s beat_q [$];
  pr_shell_pkg::stat_t     desc_exp;
  pr_shell_pkg::stat_t     line_exp;
  pr_shell_pkg::stat_t     burst_exp;
  logic                    stall_en;
  logic                    hung;
  int                      mismatch_cnt;
  int                      fail_cnt;

  pr_core_shell dut_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .core_reset        (core_reset),
    .dma_wr            (dma_wr),
    .dma_wr_valid      (dma_wr_valid),
    .dma_wr_ready      (dma_wr_ready),
    .dma_rd            (dma_rd),
    .dma_rd_valid      (dma_rd_valid),
    .dma_rd_ready      (dma_rd_ready),
    .dma_rd_resp_data  (dma_rd_resp_data),
    .dma_rd_resp_valid (dma_rd_resp_valid),
    .dma_rd_resp_ready (dma_rd_resp_ready),
    .in_desc           (in_desc),
    .in_desc_valid     (in_desc_valid),
    .in_desc_taken     (in_desc_taken),
    .out_desc          (out_desc),
    .out_desc_valid    (out_desc_valid),
    .out_desc_ready    (out_desc_ready),
    .core_status_data  (core_status_data),
    .core_status_addr  (core_status_addr)
  );

  always #4 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////
  task automatic check_line(input string name, input pr_shell_pkg::line_t got,
                            input pr_shell_pkg::line_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_desc(input string name, input pr_shell_pkg::desc_t got,
                            input pr_shell_pkg::desc_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_digest(input string name, input pr_shell_pkg::digest_t got,
                              input pr_shell_pkg::digest_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_stat(input string name, input pr_shell_pkg::stat_t got,
                            input pr_shell_pkg::stat_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input pr_shell_pkg::stat_addr_t got,
                            input pr_shell_pkg::stat_addr_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic note_timeout(input string what);
    fail_cnt++;
    hung = 1'b1;
    $display("Timed out waiting for %s at %0t ns", what, $time);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Each line folds its upper half and lower half into the digest
  function automatic pr_shell_pkg::digest_t fold_lines(input pr_shell_pkg::line_idx_t first,
                                                       input int n);
    pr_shell_pkg::digest_t   d;
    pr_shell_pkg::line_idx_t idx;
    d   = '0;
    idx = first;
    for (int k = 0; k < n; k++) begin
      d   = d ^ mem_model[idx][`PR_DATA_W-1:`PR_DESC_W] ^ mem_model[idx][`PR_DESC_W-1:0];
      idx = idx + 1'b1;
    end
    return d;
  endfunction

  // Ready stalls and capture of every accepted output beat
  always @(negedge clk) begin
    if (stall_en) begin
      dma_rd_resp_ready = ($urandom_range(3, 0) != 0);
      out_desc_ready    = ($urandom_range(3, 0) != 0);
    end else begin
      dma_rd_resp_ready = 1'b1;
      out_desc_ready    = 1'b1;
    end
    if (dma_rd_resp_valid && dma_rd_resp_ready) resp_q.push_back(dma_rd_resp_data);
    if (out_desc_valid && out_desc_ready) beat_q.push_back(out_desc);
  end

  //////////////////////////////////////////////////////////////////////
  // Operations
  //////////////////////////////////////////////////////////////////////
  task automatic write_burst(input pr_shell_pkg::line_idx_t first, input int n,
                             input logic part);
    pr_shell_pkg::dma_wr_s   beat;
    pr_shell_pkg::line_idx_t idx;
    int                      t;
    idx = first;
    for (int k = 0; k < n; k++) begin
      beat.data = {$urandom, $urandom, $urandom, $urandom};
      // Bits above 11 alias onto the same line
      beat.addr = {14'($urandom), idx, 4'h0};
      beat.strb = part ? pr_shell_pkg::strb_t'($urandom) : '1;
      beat.last = (k == n - 1);
      @(negedge clk);
      dma_wr       = beat;
      dma_wr_valid = 1'b1;
      t = 0;
      while (!dma_wr_ready && t < tmo) begin
        @(negedge clk);
        t++;
      end
      if (!dma_wr_ready) note_timeout("dma_wr_ready");
      for (int b = 0; b < `PR_STRB_W; b++) begin
        if (beat.strb[b]) mem_model[idx][8*b +: 8] = beat.data[8*b +: 8];
      end
      idx = idx + 1'b1;
    end
    @(negedge clk);
    dma_wr_valid = 1'b0;
    burst_exp++;
    repeat (4) @(negedge clk);
  endtask

  task automatic read_lines(input pr_shell_pkg::line_idx_t first, input int n);
    pr_shell_pkg::dma_rd_s   cmd;
    pr_shell_pkg::line_t     exp_q [$];
    pr_shell_pkg::line_idx_t idx;
    int                      t;
    idx = first;
    for (int k = 0; k < n; k++) begin
      cmd.addr = {14'($urandom), idx, 4'($urandom)};
      @(negedge clk);
      dma_rd       = cmd;
      dma_rd_valid = 1'b1;
      t = 0;
      while (!dma_rd_ready && t < tmo) begin
        @(negedge clk);
        t++;
      end
      if (!dma_rd_ready) note_timeout("dma_rd_ready");
      exp_q.push_back(mem_model[idx]);
      idx = idx + 1'b1;
    end
    @(negedge clk);
    dma_rd_valid = 1'b0;
    t = 0;
    while (resp_q.size() < n && t < tmo) begin
      @(posedge clk);
      t++;
    end
    if (resp_q.size() < n) note_timeout("DMA read responses");
    while (resp_q.size() > 0 && exp_q.size() > 0) begin
      check_line("dma_rd_resp_data", resp_q.pop_front(), exp_q.pop_front());
    end
  endtask

  task automatic run_desc(input pr_shell_pkg::line_idx_t first, input logic [7:0] cnt);
    pr_shell_pkg::desc_t     d;
    pr_shell_pkg::desc_t     echo;
    pr_shell_pkg::out_desc_s beat;
    int                      n;
    int                      t;
    n            = (cnt == 8'd0) ? 256 : int'(cnt);
    d.tag        = 16'($urandom);
    d.rsvd       = 24'($urandom);
    d.first_line = first;
    d.line_cnt   = cnt;
    d.done       = 8'h00;
    @(negedge clk);
    in_desc       = d;
    in_desc_valid = 1'b1;
    t = 0;
    while (!in_desc_taken && t < tmo) begin
      @(negedge clk);
      t++;
    end
    if (!in_desc_taken) note_timeout("in_desc_taken");
    @(negedge clk);
    in_desc_valid = 1'b0;
    echo      = d;
    echo.done = 8'h01;
    desc_exp++;
    line_exp += n;
    t = 0;
    while (beat_q.size() < 2 && t < desc_tmo) begin
      @(posedge clk);
      t++;
    end
    if (beat_q.size() < 2) begin
      note_timeout("output descriptor beats");
    end else begin
      beat = beat_q.pop_front();
      check_flag("out_desc.is_2nd", beat.is_2nd, 1'b0);
      check_desc("out_desc.payload", pr_shell_pkg::desc_t'(beat.payload), echo);
      beat = beat_q.pop_front();
      check_flag("out_desc.is_2nd", beat.is_2nd, 1'b1);
      check_digest("out_desc.payload", beat.payload, fold_lines(first, n));
    end
  endtask

  task automatic pulse_core_reset();
    @(negedge clk);
    core_reset = 1'b1;
    repeat (2) @(negedge clk);
    core_reset = 1'b0;
    repeat (4) @(negedge clk);
  endtask

  task automatic apply_step(input step_t s);
    stall_en = s.stall;
    case (s.op)
      op_wr:   write_burst(s.line, int'(s.cnt), s.part);
      op_rd:   read_lines(s.line, int'(s.cnt));
      op_desc: run_desc(s.line, s.cnt[7:0]);
      default: pulse_core_reset();
    endcase
  endtask

  task automatic read_status(input pr_shell_pkg::stat_addr_t a, input pr_shell_pkg::stat_t exp);
    int t;
    t = 0;
    @(negedge clk);
    while (core_status_addr != a && t < 8) begin
      @(negedge clk);
      t++;
    end
    if (core_status_addr != a) note_timeout("status address");
    else check_stat($sformatf("core_status_data[%0d]", a), core_status_data, exp);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(32'h572f51dd));
    clk           = 1'b0;
    rst_n         = 1'b0;
    core_reset    = 1'b0;
    dma_wr        = '0;
    dma_wr_valid  = 1'b0;
    dma_rd        = '0;
    dma_rd_valid  = 1'b0;
    in_desc       = '0;
    in_desc_valid = 1'b0;
    stall_en      = 1'b0;
    hung          = 1'b0;
    mismatch_cnt  = 0;
    fail_cnt      = 0;
    desc_exp      = '0;
    line_exp      = '0;
    burst_exp     = '0;

    repeat (4) @(negedge clk);
    check_flag("dma_rd_resp_valid", dma_rd_resp_valid, 1'b0);
    check_flag("out_desc_valid", out_desc_valid, 1'b0);
    check_addr("core_status_addr", core_status_addr, '0);
    rst_n = 1'b1;
    // Let the reset synchronizer release
    repeat (4) @(negedge clk);

    for (int i = 0; i < n_steps && !hung; i++) begin
      apply_step(stim[i]);
    end

    stall_en = 1'b0;
    repeat (20) @(negedge clk);
    if (resp_q.size() != 0) begin
      fail_cnt++;
      $display("Unexpected extra DMA read responses: %0d", resp_q.size());
    end
    if (beat_q.size() != 0) begin
      fail_cnt++;
      $display("Unexpected extra output descriptor beats: %0d", beat_q.size());
    end
    if (!hung) begin
      read_status(3'd0, desc_exp);
      read_status(3'd1, line_exp);
      read_status(3'd2, burst_exp);
    end

    $display("Error counts: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- pr_core_shell.f
+incdir+include
hw/pr_shell_pkg.sv
hw/pipe_reg_slice.sv
hw/line_mem.sv
hw/desc_engine_fsm.sv
hw/event_counters.sv
hw/packet_core.sv
hw/pr_core_shell.sv
verif/pr_core_shell_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f pr_core_shell.f \
  --top-module pr_core_shell_tb -o sim_bin > build.log 2>&1 &&
./obj_dir/sim_bin > sim.log 2>&1 ||
{ echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "All checks passed" sim.log &&
echo "PASS" ||
{ echo "FAIL, see sim.log"; exit 1; }
